// ==== led_pkg.sv ====
// LED matrix shared definitions
package led_pkg;

	// panel geometry and pixel format
	localparam int SEGMENTS = 1;
	localparam int ROWS = 8;
	localparam int COLUMNS = 32;
	localparam int BITWIDTH = 8;
	localparam int CHANNELS = 3;
	localparam int PIXEL_W = SEGMENTS * CHANNELS * BITWIDTH;
	localparam int ROW_W = $clog2(ROWS);
	localparam int COL_W = $clog2(COLUMNS);
	// counts the colour bytes within one pixel word
	localparam int CH_W = $clog2(SEGMENTS * CHANNELS);

	// byte stream commands
	localparam logic [3:0] CMD_LOAD_NIBBLE = 4'hf;
	localparam logic [7:0] CMD_FLIP = 8'h10;

	// AXI4-Lite register map
	localparam int AXIL_AW = 4;
	localparam int AXIL_DW = 32;
	localparam logic [AXIL_AW-1:0] REG_CTRL = 4'h0;
	localparam logic [AXIL_AW-1:0] REG_STATUS = 4'h4;

	// pixel write request into the back buffer
	typedef struct packed {
		logic en;
		logic [ROW_W-1:0] row;
		logic [COL_W-1:0] col;
		logic [PIXEL_W-1:0] data;
	} pix_wr_t;

	// scanned pixel with its position
	typedef struct packed {
		logic valid;
		logic frame_end;
		logic [ROW_W-1:0] row;
		logic [COL_W-1:0] col;
		logic [PIXEL_W-1:0] data;
	} pix_out_t;

	// master to slave AXI4-Lite channels
	typedef struct packed {
		logic awvalid;
		logic [AXIL_AW-1:0] awaddr;
		logic wvalid;
		logic [AXIL_DW-1:0] wdata;
		logic bready;
		logic arvalid;
		logic [AXIL_AW-1:0] araddr;
		logic rready;
	} axil_req_t;

	// slave to master AXI4-Lite channels
	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [AXIL_DW-1:0] rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

endpackage

// ==== data_loader.sv ====
// Command stream loader
`timescale 1ns/10ps

module data_loader import led_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [7:0] idata,
	input logic ivalid,
	input logic ready,
	output pix_wr_t wr,
	output logic loaded
);

	typedef enum logic {
		ST_WAIT,
		ST_LOAD
	} state_t;

	state_t state;
	// byte position inside the current pixel
	logic [CH_W-1:0] channel;
	// column of the pixel being assembled
	logic [COL_W-1:0] column;
	// ready as seen when the row command arrived
	logic wr_allow;

	// write request registers
	logic wen;
	logic [ROW_W-1:0] wrow;
	logic [COL_W-1:0] wcol;
	logic [PIXEL_W-1:0] wdata;

	assign wr = '{en: wen, row: wrow, col: wcol, data: wdata};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_WAIT;
			channel <= '0;
			column <= '0;
			wr_allow <= 1'b0;
			wen <= 1'b0;
			loaded <= 1'b0;
		end else begin
			// both strobes last a single cycle
			wen <= 1'b0;
			loaded <= 1'b0;
			case (state)
				ST_WAIT: begin
					if (ivalid) begin
						if (idata[7:4] == CMD_LOAD_NIBBLE) begin
							// row select in the low bits, payload bytes follow
							channel <= '0;
							column <= '0;
							wr_allow <= ready;
							state <= ST_LOAD;
						end else if (idata == CMD_FLIP && ready) begin
							// frame complete, request a flip
							loaded <= 1'b1;
						end
						// anything else is dropped
					end
				end
				ST_LOAD: begin
					if (ivalid) begin
						if (channel == CH_W'(SEGMENTS * CHANNELS - 1)) begin
							// last byte of this pixel
							wen <= wr_allow;
							channel <= '0;
							if (column == COL_W'(COLUMNS - 1)) begin
								column <= '0;
								state <= ST_WAIT;
							end else begin
								column <= column + 1'b1;
							end
						end else begin
							channel <= channel + 1'b1;
						end
					end
				end
				default: state <= ST_WAIT;
			endcase
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if (ivalid && state == ST_WAIT && idata[7:4] == CMD_LOAD_NIBBLE) begin
			wrow <= idata[ROW_W-1:0];
		end
		if (ivalid && state == ST_LOAD) begin
			// first byte ends up in the top bits
			wdata <= {wdata[PIXEL_W-BITWIDTH-1:0], idata};
			wcol <= column;
		end
	end

endmodule

// ==== frame_buffer.sv ====
// Double-buffered frame memory
`timescale 1ns/10ps

module frame_buffer import led_pkg::*; (
	input logic clk,
	input logic rst,
	input pix_wr_t wr,
	input logic loaded,
	input logic [ROW_W-1:0] rd_row,
	input logic [COL_W-1:0] rd_col,
	output logic [PIXEL_W-1:0] rd_data,
	input logic frame_end,
	input logic scan_enable,
	output logic ready,
	output logic front,
	output logic pending,
	output logic [7:0] flip_count
);

	// two halves, index by front or back
	logic [PIXEL_W-1:0] mem [0:1][0:ROWS-1][0:COLUMNS-1];
	// swap happens in this cycle
	logic flip_now;
	// half used by the read issued this cycle
	logic rd_half;

	// at the last pixel of a frame, or right away when idle
	assign flip_now = pending && (frame_end || !scan_enable);

	// the read issued alongside frame_end is the first of the new frame,
	// so it already looks at the half that becomes front
	assign rd_half = front ^ flip_now;

	// loader may only write while nothing waits to be flipped
	assign ready = !pending;

	always_ff @(posedge clk) begin
		if (wr.en) begin
			// loader always fills the back half
			mem[~front][wr.row][wr.col] <= wr.data;
		end
		// one cycle read latency
		rd_data <= mem[rd_half][rd_row][rd_col];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			front <= 1'b0;
			pending <= 1'b0;
			flip_count <= 8'd0;
		end else begin
			if (flip_now) begin
				front <= ~front;
				flip_count <= flip_count + 8'd1;
				pending <= 1'b0;
			end else if (loaded) begin
				// wait for the scanner to reach a frame boundary
				pending <= 1'b1;
			end
		end
	end

endmodule

// ==== scan_out.sv ====
// Front buffer scanner
`timescale 1ns/10ps

module scan_out import led_pkg::*; (
	input logic clk,
	input logic rst,
	input logic enable,
	output logic [ROW_W-1:0] rd_row,
	output logic [COL_W-1:0] rd_col,
	input logic [PIXEL_W-1:0] rd_data,
	output pix_out_t pix
);

	// read address counters
	logic [ROW_W-1:0] row;
	logic [COL_W-1:0] col;
	// address that went out with the pending read
	logic [ROW_W-1:0] row_q;
	logic [COL_W-1:0] col_q;
	logic valid_q;
	logic frame_end_q;

	assign rd_row = row;
	assign rd_col = col;

	// row-major walk over the panel
	always_ff @(posedge clk) begin
		if (rst || !enable) begin
			row <= '0;
			col <= '0;
		end else if (col == COL_W'(COLUMNS - 1)) begin
			col <= '0;
			row <= (row == ROW_W'(ROWS - 1)) ? '0 : row + 1'b1;
		end else begin
			col <= col + 1'b1;
		end
	end

	// control side of the one-stage pipeline
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
			frame_end_q <= 1'b0;
		end else begin
			valid_q <= enable;
			frame_end_q <= enable && row == ROW_W'(ROWS - 1) && col == COL_W'(COLUMNS - 1);
		end
	end

	always_ff @(posedge clk) begin
		row_q <= row;
		col_q <= col;
	end

	// memory data lands together with its address
	assign pix = '{valid: valid_q, frame_end: frame_end_q, row: row_q, col: col_q,
		data: rd_data};

endmodule

// ==== ctrl_regs.sv ====
// AXI4-Lite control registers
`timescale 1ns/10ps

module ctrl_regs import led_pkg::*; (
	input logic clk,
	input logic rst,
	input axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	output logic enable,
	input logic front,
	input logic pending,
	input logic [7:0] flip_count
);

	logic awready;
	logic bvalid;
	logic arready;
	logic rvalid;
	logic [AXIL_DW-1:0] rdata;
	logic [AXIL_DW-1:0] status;

	// front in bit 0, pending in bit 1, counter in the second byte
	assign status = {16'd0, flip_count, 6'd0, pending, front};

	// write channel
	always_ff @(posedge clk) begin
		if (rst) begin
			awready <= 1'b0;
			bvalid <= 1'b0;
			enable <= 1'b0;
		end else begin
			// address and data accepted together, one at a time
			awready <= axil_req.awvalid && axil_req.wvalid && !bvalid && !awready;
			if (awready) begin
				bvalid <= 1'b1;
				// status is read only
				if (axil_req.awaddr == REG_CTRL) begin
					enable <= axil_req.wdata[0];
				end
			end else if (bvalid && axil_req.bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// read channel
	always_ff @(posedge clk) begin
		if (rst) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= axil_req.arvalid && !rvalid && !arready;
			if (arready) begin
				rvalid <= 1'b1;
			end else if (rvalid && axil_req.rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// read data is captured with the address
	always_ff @(posedge clk) begin
		if (arready) begin
			case (axil_req.araddr)
				REG_CTRL: rdata <= {31'd0, enable};
				REG_STATUS: rdata <= status;
				default: rdata <= '0;
			endcase
		end
	end

	// responses are always OKAY
	assign axil_rsp = '{
		awready: awready,
		wready: awready,
		bvalid: bvalid,
		bresp: 2'b00,
		arready: arready,
		rvalid: rvalid,
		rdata: rdata,
		rresp: 2'b00
	};

endmodule

// ==== led_matrix_top.sv ====
// LED matrix controller top
`timescale 1ns/10ps

module led_matrix_top import led_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [7:0] idata,
	input logic ivalid,
	input axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	output pix_out_t pix
);

	// loader to memory
	pix_wr_t wr;
	logic loaded;
	logic ready;
	// scanner read path
	logic [ROW_W-1:0] rd_row;
	logic [COL_W-1:0] rd_col;
	logic [PIXEL_W-1:0] rd_data;
	// status and control
	logic front;
	logic pending;
	logic [7:0] flip_count;
	logic enable;

	data_loader loader0 (
		.clk(clk),
		.rst(rst),
		.idata(idata),
		.ivalid(ivalid),
		.ready(ready),
		.wr(wr),
		.loaded(loaded)
	);

	// flip boundary taken from the scanner output
	frame_buffer fb0 (
		.clk(clk),
		.rst(rst),
		.wr(wr),
		.loaded(loaded),
		.rd_row(rd_row),
		.rd_col(rd_col),
		.rd_data(rd_data),
		.frame_end(pix.frame_end),
		.scan_enable(enable),
		.ready(ready),
		.front(front),
		.pending(pending),
		.flip_count(flip_count)
	);

	scan_out scan0 (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.rd_row(rd_row),
		.rd_col(rd_col),
		.rd_data(rd_data),
		.pix(pix)
	);

	ctrl_regs regs0 (
		.clk(clk),
		.rst(rst),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.enable(enable),
		.front(front),
		.pending(pending),
		.flip_count(flip_count)
	);

endmodule

// ==== tb_led_matrix.sv ====
// LED matrix controller testbench
`timescale 1ns/10ps

module tb_led_matrix import led_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int FRAME_CYCLES = ROWS * COLUMNS;
	// command byte plus three colour bytes per column
	localparam int ROW_BYTES = 1 + COLUMNS * CHANNELS;
	// frame waits, streamed rows and register accesses of all tests
	localparam int TEST_CYCLES = 24 * FRAME_CYCLES + (2 * ROWS + 1) * ROW_BYTES + 50 * 8;
	localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;
	localparam int MAX_POLLS = 100;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic [7:0] idata = 8'd0;
	logic ivalid = 1'b0;
	axil_req_t req = '0;
	axil_rsp_t rsp;
	pix_out_t pix;

	integer seed = 88;

	// reference model of both halves and the flip state
	logic [PIXEL_W-1:0] model_mem [0:1][0:ROWS-1][0:COLUMNS-1];
	logic model_front;
	logic model_pending;
	logic [7:0] model_count;
	logic model_loaded;
	logic model_enable = 1'b0;
	// marks the cycle that carries a flip command byte
	logic flip_byte = 1'b0;
	// expected status at the moment the DUT captured its read data
	logic [AXIL_DW-1:0] status_snap;

	always #(CLK_PERIOD / 2) clk = ~clk;

	led_matrix_top dut0 (
		.clk(clk),
		.rst(rst),
		.idata(idata),
		.ivalid(ivalid),
		.axil_req(req),
		.axil_rsp(rsp),
		.pix(pix)
	);

	// flip bookkeeping, one step per clock like the hardware
	always @(posedge clk) begin
		if (rst) begin
			model_front <= 1'b0;
			model_pending <= 1'b0;
			model_count <= 8'd0;
			model_loaded <= 1'b0;
		end else begin
			// swap at the frame end pixel, or at once while idle
			if (model_pending && (pix.frame_end || !model_enable)) begin
				model_front <= !model_front;
				model_count <= model_count + 8'd1;
				model_pending <= 1'b0;
			end else if (model_loaded) begin
				model_pending <= 1'b1;
			end
			// flip byte only counts while ready
			model_loaded <= flip_byte && !model_pending;
		end
	end

	function automatic logic [AXIL_DW-1:0] model_status();
		return {16'd0, model_count, 6'd0, model_pending, model_front};
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic expect_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			fail_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic axi_write(input logic [AXIL_AW-1:0] addr, input logic [AXIL_DW-1:0] data);
		@(posedge clk);
		req.awvalid <= 1'b1;
		req.awaddr <= addr;
		req.wvalid <= 1'b1;
		req.wdata <= data;
		req.bready <= 1'b1;
		do
			@(posedge clk);
		while (!rsp.awready);
		// address and data are taken in the same cycle
		expect_equal("axil_rsp.wready", 32'(rsp.wready), 32'd1);
		// the register takes the value at this edge
		if (addr == REG_CTRL) begin
			model_enable <= data[0];
		end
		req.awvalid <= 1'b0;
		req.wvalid <= 1'b0;
		do
			@(posedge clk);
		while (!rsp.bvalid);
		expect_equal("axil_rsp.bresp", 32'(rsp.bresp), 32'd0);
		req.bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [AXIL_AW-1:0] addr, output logic [AXIL_DW-1:0] data);
		@(posedge clk);
		req.arvalid <= 1'b1;
		req.araddr <= addr;
		req.rready <= 1'b1;
		do
			@(posedge clk);
		while (!rsp.arready);
		// read data is taken from the registers at this edge
		status_snap = model_status();
		req.arvalid <= 1'b0;
		do
			@(posedge clk);
		while (!rsp.rvalid);
		data = rsp.rdata;
		expect_equal("axil_rsp.rresp", 32'(rsp.rresp), 32'd0);
		req.rready <= 1'b0;
	endtask

	task automatic send_byte(input logic [7:0] b);
		@(posedge clk);
		idata <= b;
		ivalid <= 1'b1;
	endtask

	task automatic stream_idle();
		@(posedge clk);
		ivalid <= 1'b0;
		flip_byte <= 1'b0;
	endtask

	task automatic load_row(input int r);
		logic [PIXEL_W-1:0] px;
		logic allow;
		logic back;
		int c;
		int ch;
		allow = 1'b0;
		back = 1'b0;
		send_byte({CMD_LOAD_NIBBLE, 4'(r)});
		for (c = 0; c < COLUMNS; c++) begin
			px = PIXEL_W'($random(seed));
			// first byte of a pixel is its top channel
			for (ch = CHANNELS - 1; ch >= 0; ch--) begin
				send_byte(px[ch * BITWIDTH +: BITWIDTH]);
				if (c == 0 && ch == CHANNELS - 1) begin
					// the row command is sampled at this edge
					allow = !model_pending;
					back = !model_front;
				end
			end
			if (allow) begin
				model_mem[back][r][c] = px;
			end
		end
		stream_idle();
	endtask

	task automatic flip();
		send_byte(CMD_FLIP);
		flip_byte <= 1'b1;
		stream_idle();
	endtask

	// one full frame starting after the next frame end
	task automatic check_frame(input logic with_data);
		int n;
		int r;
		int c;
		logic half;
		do
			@(posedge clk);
		while (!(pix.valid && pix.frame_end));
		half = 1'b0;
		for (n = 0; n < FRAME_CYCLES; n++) begin
			@(posedge clk);
			if (n == 0) begin
				// any swap at that frame end is already in the model
				half = model_front;
			end
			r = n / COLUMNS;
			c = n % COLUMNS;
			expect_equal("pix.valid", 32'(pix.valid), 32'd1);
			expect_equal("pix.row", 32'(pix.row), 32'(r));
			expect_equal("pix.col", 32'(pix.col), 32'(c));
			expect_equal("pix.frame_end", 32'(pix.frame_end), 32'(n == FRAME_CYCLES - 1));
			if (with_data) begin
				expect_equal("pix.data", 32'(pix.data), 32'(model_mem[half][r][c]));
			end
		end
	endtask

	// poll status until the pending flag drops
	task automatic wait_flip_done();
		logic [AXIL_DW-1:0] rd;
		int polls;
		polls = 0;
		rd = 32'h2;
		while (rd[1] && polls < MAX_POLLS) begin
			axi_read(REG_STATUS, rd);
			expect_equal("status", rd, status_snap);
			polls++;
		end
		assert (!rd[1]) else begin
			fail_run("the flip stayed pending for too long");
		end
	endtask

	task automatic reset_values();
		logic [AXIL_DW-1:0] rd;
		int i;
		for (i = 0; i < 20; i++) begin
			@(posedge clk);
			expect_equal("pix.valid", 32'(pix.valid), 32'd0);
		end
		axi_read(REG_CTRL, rd);
		expect_equal("ctrl", rd, 32'd0);
		axi_read(REG_STATUS, rd);
		expect_equal("status", rd, 32'd0);
	endtask

	task automatic scan_order();
		logic [AXIL_DW-1:0] rd;
		axi_write(REG_CTRL, 32'd1);
		axi_read(REG_CTRL, rd);
		expect_equal("ctrl", rd, 32'd1);
		// memory is still empty, so only positions count
		check_frame(1'b0);
		axi_write(REG_CTRL, 32'd0);
	endtask

	task automatic first_frame();
		logic [AXIL_DW-1:0] rd;
		int r;
		for (r = 0; r < ROWS; r++) begin
			load_row(r);
		end
		flip();
		// idle scanner swaps right after pending is set
		repeat (4) @(posedge clk);
		axi_read(REG_STATUS, rd);
		expect_equal("status", rd, status_snap);
		expect_equal("status", rd, 32'h0000_0101);
		axi_write(REG_CTRL, 32'd1);
		check_frame(1'b1);
	endtask

	task automatic live_reload();
		logic [AXIL_DW-1:0] rd;
		int r;
		for (r = 0; r < ROWS; r++) begin
			load_row(r);
		end
		// old picture still on display
		check_frame(1'b1);
		flip();
		check_frame(1'b1);
		wait_flip_done();
		check_frame(1'b1);
		axi_read(REG_STATUS, rd);
		expect_equal("status", rd, status_snap);
		expect_equal("status", rd, 32'h0000_0200);
	endtask

	task automatic dropped_row();
		logic [AXIL_DW-1:0] rd;
		flip();
		// pending is already set when this row command lands
		load_row(3);
		wait_flip_done();
		check_frame(1'b1);
		flip();
		wait_flip_done();
		check_frame(1'b1);
		axi_read(REG_STATUS, rd);
		expect_equal("status", rd, status_snap);
		expect_equal("status", rd, 32'h0000_0400);
	endtask

	task automatic junk_bytes();
		logic [AXIL_DW-1:0] rd;
		send_byte(8'h00);
		send_byte(8'h5a);
		send_byte(8'he3);
		send_byte(8'h11);
		send_byte(8'h0f);
		send_byte(8'h7f);
		stream_idle();
		check_frame(1'b1);
		axi_read(REG_STATUS, rd);
		expect_equal("status", rd, status_snap);
		expect_equal("status", rd, 32'h0000_0400);
		// back half comes to the front and must still hold the older picture
		flip();
		wait_flip_done();
		check_frame(1'b1);
		axi_read(REG_STATUS, rd);
		expect_equal("status", rd, status_snap);
		expect_equal("status", rd, 32'h0000_0501);
	endtask

	initial begin
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		reset_values();
		scan_order();
		first_frame();
		live_reload();
		dropped_row();
		junk_bytes();
		$display("TEST PASSED");
		$finish;
	end

	// guard against a stuck handshake or a scanner that never ends a frame
	initial begin
		#(WATCHDOG_NS);
		fail_run("timeout, the tests did not finish in time");
	end

endmodule

// ==== filelist.f ====
led_pkg.sv
data_loader.sv
frame_buffer.sv
scan_out.sv
ctrl_regs.sv
led_matrix_top.sv
tb_led_matrix.sv

// ==== run.sh ====
#!/bin/sh
# build and run the LED matrix testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_led_matrix -f filelist.f -o sim_led_matrix
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/sim_led_matrix 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "TEST PASSED"; then
	exit 0
fi
exit 1
